/* hdl/paillier_pkg.sv */
`default_nettype none

package paillier_pkg;

    // Streamed number format
    localparam int limb_w     = 16;
    localparam int limb_count = 4;
    localparam int num_w      = limb_w * limb_count;
    localparam int limb_idx_w = 2;
    localparam int bit_idx_w  = 6;

    // Fixed odd modulus, stands in for n squared
    localparam logic [num_w-1:0] modulus = 64'hE3A1_5C7F_0B29_D46B;

    typedef enum logic {
        cmd_homo_add   = 1'b0,
        cmd_scalar_mul = 1'b1
    } cmd_t;

    typedef logic [limb_w-1:0] limb_t;
    typedef logic [num_w-1:0]  num_t;

endpackage

`default_nettype wire

/* hdl/mod_mult.sv */
`default_nettype none
`timescale 1ns/1ps

module mod_mult import paillier_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic mm_start,
    input  num_t mm_a,
    input  num_t mm_b,
    output num_t mm_result,
    output logic mm_done
);

    localparam logic [num_w:0]       mod_ext  = {1'b0, modulus};
    localparam logic [bit_idx_w-1:0] last_bit = bit_idx_w'(num_w - 1);

    logic                 busy;
    logic [bit_idx_w-1:0] bit_cnt;
    num_t                 a_r;
    num_t                 b_sh;
    num_t                 acc;
    logic [num_w:0]       dbl_sum;
    logic [num_w:0]       dbl_diff;
    num_t                 dbl_mod;
    logic [num_w:0]       add_sum;
    logic [num_w:0]       add_diff;
    num_t                 add_mod;
    num_t                 acc_next;

    // One step: 2*acc mod M, then + a mod M if the scanned bit is set
    always_comb begin
        dbl_sum  = {acc, 1'b0};
        dbl_diff = dbl_sum - mod_ext;
        dbl_mod  = (dbl_sum >= mod_ext) ? dbl_diff[num_w-1:0] : dbl_sum[num_w-1:0];
        add_sum  = {1'b0, dbl_mod} + {1'b0, a_r};
        add_diff = add_sum - mod_ext;
        add_mod  = (add_sum >= mod_ext) ? add_diff[num_w-1:0] : add_sum[num_w-1:0];
        acc_next = b_sh[num_w-1] ? add_mod : dbl_mod;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            mm_done <= 1'b0;
        end else begin
            mm_done <= 1'b0;
            if (mm_start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == last_bit) begin
                    busy    <= 1'b0;
                    mm_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mm_start) begin
            a_r  <= mm_a;
            b_sh <= mm_b;
            acc  <= '0;
        end else if (busy) begin
            acc  <= acc_next;
            b_sh <= b_sh << 1;
        end
    end

    assign mm_result = acc;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start |-> !busy);

endmodule

`default_nettype wire

/* hdl/operand_collector.sv */
`default_nettype none
`timescale 1ns/1ps

module operand_collector import paillier_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  task_req,
    input  cmd_t  task_cmd,
    input  limb_t a_data,
    input  logic  a_valid,
    input  limb_t b_data,
    input  logic  b_valid,
    output logic  task_ready,
    output logic  op_req,
    output cmd_t  op_cmd,
    output num_t  op_a,
    output num_t  op_b,
    input  logic  op_ack
);

    localparam logic [limb_idx_w-1:0] last_limb = limb_idx_w'(limb_count - 1);

    logic                  accept;
    logic                  a_take;
    logic                  b_take;
    logic [limb_idx_w-1:0] a_cnt;
    logic [limb_idx_w-1:0] b_cnt;
    logic                  a_done;
    logic                  b_done;
    cmd_t                  cmd_r;
    num_t                  a_r;
    num_t                  b_r;

    assign accept = task_ready && task_req;
    assign a_take = !task_ready && !a_done && a_valid;
    assign b_take = !task_ready && !b_done && b_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            task_ready <= 1'b1;
            op_req     <= 1'b0;
            a_cnt      <= '0;
            b_cnt      <= '0;
            a_done     <= 1'b0;
            b_done     <= 1'b0;
        end else begin
            if (accept) begin
                task_ready <= 1'b0;
                a_cnt      <= '0;
                b_cnt      <= '0;
                a_done     <= 1'b0;
                b_done     <= 1'b0;
            end
            if (a_take) begin
                a_cnt <= a_cnt + 1'b1;
                if (a_cnt == last_limb) begin
                    a_done <= 1'b1;
                end
            end
            if (b_take) begin
                b_cnt <= b_cnt + 1'b1;
                if (b_cnt == last_limb) begin
                    b_done <= 1'b1;
                end
            end
            // Previous ack must be gone before a new request
            if (!task_ready && a_done && b_done && !op_req && !op_ack) begin
                op_req <= 1'b1;
            end
            if (op_req && op_ack) begin
                op_req     <= 1'b0;
                task_ready <= 1'b1;
            end
        end
    end

    // Limbs enter at the top, LSB limb first
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_r <= task_cmd;
        end
        if (a_take) begin
            a_r <= {a_data, a_r[num_w-1:limb_w]};
        end
        if (b_take) begin
            b_r <= {b_data, b_r[num_w-1:limb_w]};
        end
    end

    assign op_cmd = cmd_r;
    assign op_a   = a_r;
    assign op_b   = b_r;

    a_op_a_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        op_req |-> op_a < modulus);

    a_op_b_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        op_req && op_cmd == cmd_homo_add |-> op_b < modulus);

endmodule

`default_nettype wire

/* hdl/homo_op_engine.sv */
`default_nettype none
`timescale 1ns/1ps

module homo_op_engine import paillier_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic op_req,
    input  cmd_t op_cmd,
    input  num_t op_a,
    input  num_t op_b,
    output logic op_ack,
    output logic res_req,
    output num_t res_data,
    input  logic res_ack
);

    localparam logic [bit_idx_w-1:0] last_bit = bit_idx_w'(num_w - 1);

    typedef enum logic [2:0] {
        s_idle,
        s_issue,
        s_wait,
        s_done,
        s_release
    } state_t;

    state_t               state;
    cmd_t                 cmd_r;
    logic [bit_idx_w-1:0] bit_cnt;
    logic                 mul_step;
    num_t                 base_r;
    num_t                 exp_r;
    num_t                 acc_r;
    logic                 capture;
    logic                 step_end;
    logic                 need_mul;
    logic                 mm_start;
    num_t                 mm_a;
    num_t                 mm_b;
    num_t                 mm_result;
    logic                 mm_done;

    assign capture  = (state == s_idle) && op_req && !op_ack;
    assign step_end = (state == s_wait) && mm_done;
    // Square just finished and the current exponent bit is set
    assign need_mul = (cmd_r == cmd_scalar_mul) && !mul_step && exp_r[num_w-1];

    assign mm_start = (state == s_issue);
    assign mm_a     = mul_step ? base_r : acc_r;
    assign mm_b     = acc_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= s_idle;
            op_ack   <= 1'b0;
            cmd_r    <= cmd_homo_add;
            bit_cnt  <= '0;
            mul_step <= 1'b0;
        end else begin
            if (capture) begin
                op_ack <= 1'b1;
            end else if (op_ack && !op_req) begin
                op_ack <= 1'b0;
            end
            case (state)
                s_idle: begin
                    if (capture) begin
                        cmd_r    <= op_cmd;
                        bit_cnt  <= '0;
                        // Addition is a single multiply step a*b
                        mul_step <= (op_cmd == cmd_homo_add);
                        state    <= s_issue;
                    end
                end
                s_issue: begin
                    state <= s_wait;
                end
                s_wait: begin
                    if (mm_done) begin
                        if (cmd_r == cmd_homo_add) begin
                            state <= s_done;
                        end else if (need_mul) begin
                            mul_step <= 1'b1;
                            state    <= s_issue;
                        end else begin
                            mul_step <= 1'b0;
                            if (bit_cnt == last_bit) begin
                                state <= s_done;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                state   <= s_issue;
                            end
                        end
                    end
                end
                s_done: begin
                    if (res_ack) begin
                        state <= s_release;
                    end
                end
                s_release: begin
                    if (!res_ack) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            base_r <= op_a;
            exp_r  <= op_b;
            acc_r  <= (op_cmd == cmd_homo_add) ? op_b : num_t'(1);
        end else if (step_end) begin
            acc_r <= mm_result;
            // Move to the next exponent bit once its steps are done
            if (cmd_r == cmd_scalar_mul && !need_mul) begin
                exp_r <= exp_r << 1;
            end
        end
    end

    assign res_req  = (state == s_done);
    assign res_data = acc_r;

    mod_mult i_mod_mult (
        .clk       (clk),
        .rst_n     (rst_n),
        .mm_start  (mm_start),
        .mm_a      (mm_a),
        .mm_b      (mm_b),
        .mm_result (mm_result),
        .mm_done   (mm_done)
    );

    a_res_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        res_req |-> res_data < modulus);

endmodule

`default_nettype wire

/* hdl/result_serializer.sv */
`default_nettype none
`timescale 1ns/1ps

module result_serializer import paillier_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  res_req,
    input  num_t  res_data,
    output logic  res_ack,
    output limb_t out_data,
    output logic  out_valid,
    output logic  task_end
);

    localparam logic [limb_idx_w-1:0] last_limb = limb_idx_w'(limb_count - 1);

    logic                  capture;
    logic [limb_idx_w-1:0] limb_cnt;
    num_t                  data_sh;

    assign capture = res_req && !res_ack;

    // out_valid doubles as the streaming flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_ack   <= 1'b0;
            out_valid <= 1'b0;
            limb_cnt  <= '0;
        end else begin
            if (capture) begin
                res_ack   <= 1'b1;
                out_valid <= 1'b1;
                limb_cnt  <= '0;
            end else if (out_valid) begin
                limb_cnt <= limb_cnt + 1'b1;
                if (limb_cnt == last_limb) begin
                    out_valid <= 1'b0;
                end
            end else if (res_ack && !res_req) begin
                res_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_sh <= res_data;
        end else if (out_valid) begin
            data_sh <= data_sh >> limb_w;
        end
    end

    assign out_data = data_sh[limb_w-1:0];
    assign task_end = out_valid && (limb_cnt == last_limb);

endmodule

`default_nettype wire

/* hdl/paillier_top.sv */
`default_nettype none
`timescale 1ns/1ps

module paillier_top import paillier_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  task_req,
    input  cmd_t  task_cmd,
    input  limb_t a_data,
    input  logic  a_valid,
    input  limb_t b_data,
    input  logic  b_valid,
    output logic  task_ready,
    output limb_t out_data,
    output logic  out_valid,
    output logic  task_end
);

    // Collector to engine link
    logic op_req;
    logic op_ack;
    cmd_t op_cmd;
    num_t op_a;
    num_t op_b;

    // Engine to serializer link
    logic res_req;
    logic res_ack;
    num_t res_data;

    operand_collector i_operand_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .task_req   (task_req),
        .task_cmd   (task_cmd),
        .a_data     (a_data),
        .a_valid    (a_valid),
        .b_data     (b_data),
        .b_valid    (b_valid),
        .task_ready (task_ready),
        .op_req     (op_req),
        .op_cmd     (op_cmd),
        .op_a       (op_a),
        .op_b       (op_b),
        .op_ack     (op_ack)
    );

    homo_op_engine i_homo_op_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_req   (op_req),
        .op_cmd   (op_cmd),
        .op_a     (op_a),
        .op_b     (op_b),
        .op_ack   (op_ack),
        .res_req  (res_req),
        .res_data (res_data),
        .res_ack  (res_ack)
    );

    result_serializer i_result_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_req   (res_req),
        .res_data  (res_data),
        .res_ack   (res_ack),
        .out_data  (out_data),
        .out_valid (out_valid),
        .task_end  (task_end)
    );

endmodule

`default_nettype wire

/* test/tb_paillier_model.svh */
`ifndef TB_PAILLIER_MODEL_SVH
`define TB_PAILLIER_MODEL_SVH

// Reference arithmetic on full-width integers

// a*b mod modulus through a double-width product
function automatic paillier_pkg::num_t expected_product(
    input paillier_pkg::num_t a,
    input paillier_pkg::num_t b
);
    logic [127:0] prod;
    logic [127:0] rem;
    prod = {64'b0, a} * {64'b0, b};
    rem  = prod % {64'b0, paillier_pkg::modulus};
    return rem[63:0];
endfunction

// base**k mod modulus, square and multiply from the top bit of k
function automatic paillier_pkg::num_t expected_power(
    input paillier_pkg::num_t base,
    input paillier_pkg::num_t k
);
    paillier_pkg::num_t result;
    result = 64'd1;
    for (int i = 63; i >= 0; i--) begin
        result = expected_product(result, result);
        if (k[i]) begin
            result = expected_product(result, base);
        end
    end
    return result;
endfunction

`endif

/* test/tb_paillier_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "tb_paillier_model.svh"

module tb_paillier_top import paillier_pkg::*; ();

    localparam int ready_timeout = 20000;
    localparam int drain_timeout = 60000;

    logic  clk;
    logic  rst_n;
    logic  task_req;
    cmd_t  task_cmd;
    limb_t a_data;
    logic  a_valid;
    limb_t b_data;
    logic  b_valid;
    logic  task_ready;
    limb_t out_data;
    logic  out_valid;
    logic  task_end;

    num_t  expected_q[$];
    int    results_seen;
    int    limb_pos;
    num_t  assembled;
    logic  frame_done;

    paillier_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .task_req   (task_req),
        .task_cmd   (task_cmd),
        .a_data     (a_data),
        .a_valid    (a_valid),
        .b_data     (b_data),
        .b_valid    (b_valid),
        .task_ready (task_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .task_end   (task_end)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic stop_on_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > ready_timeout) begin
                stop_on_failure("task_ready did not return in time");
            end
        end while (!task_ready);
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > drain_timeout) begin
                stop_on_failure("results still missing when the output went quiet");
            end
        end
    endtask

    function automatic num_t rand_residue();
        num_t v;
        v = {$urandom(), $urandom()};
        return v % modulus;
    endfunction

    // Issue one task, then stream both operands limb by limb
    task automatic send_task(input cmd_t cmd, input num_t a, input num_t b, input bit gapped);
        int   a_idx;
        int   b_idx;
        num_t expected;
        expected = (cmd == cmd_homo_add) ? expected_product(a, b) : expected_power(a, b);
        wait_for_ready();
        expected_q.push_back(expected);
        task_req <= 1'b1;
        task_cmd <= cmd;
        @(posedge clk);
        task_req <= 1'b0;
        a_idx = 0;
        b_idx = 0;
        while (a_idx < limb_count || b_idx < limb_count) begin
            if (a_idx < limb_count && (!gapped || $urandom_range(0, 2) != 0)) begin
                a_valid <= 1'b1;
                a_data  <= a[a_idx*limb_w +: limb_w];
                a_idx++;
            end else begin
                a_valid <= 1'b0;
                a_data  <= limb_t'($urandom());
            end
            if (b_idx < limb_count && (!gapped || $urandom_range(0, 3) != 0)) begin
                b_valid <= 1'b1;
                b_data  <= b[b_idx*limb_w +: limb_w];
                b_idx++;
            end else begin
                b_valid <= 1'b0;
                b_data  <= limb_t'($urandom());
            end
            @(posedge clk);
        end
        a_valid <= 1'b0;
        b_valid <= 1'b0;
    endtask

    // Output monitor: framing and comparison in issue order
    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (frame_done) begin
                    stop_on_failure("out_valid stayed high past the last limb");
                end
                assembled[limb_pos*limb_w +: limb_w] = out_data;
                check_value("task_end", 64'(task_end), 64'(limb_pos == limb_count - 1));
                if (limb_pos == limb_count - 1) begin
                    if (expected_q.size() == 0) begin
                        stop_on_failure("result arrived with no task outstanding");
                    end
                    check_value($sformatf("result %0d", results_seen), assembled,
                                expected_q.pop_front());
                    results_seen++;
                    limb_pos   = 0;
                    frame_done = 1'b1;
                end else begin
                    limb_pos++;
                    frame_done = 1'b0;
                end
            end else begin
                if (limb_pos != 0) begin
                    stop_on_failure("out_valid dropped before the last limb");
                end
                check_value("task_end", 64'(task_end), 64'd0);
                frame_done = 1'b0;
            end
        end
    end

    initial begin
        num_t a;
        num_t b;
        cmd_t cmd;

        clk          = 1'b0;
        rst_n        = 1'b0;
        task_req     = 1'b0;
        task_cmd     = cmd_homo_add;
        a_data       = '0;
        a_valid      = 1'b0;
        b_data       = '0;
        b_valid      = 1'b0;
        results_seen = 0;
        limb_pos     = 0;
        assembled    = '0;
        frame_done   = 1'b0;
        void'($urandom(32'hf44cccd5));

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("task_ready after reset", 64'(task_ready), 64'd1);
        check_value("out_valid after reset", 64'(out_valid), 64'd0);
        check_value("task_end after reset", 64'(task_end), 64'd0);

        // Homomorphic addition
        for (int i = 0; i < 20; i++) begin
            send_task(cmd_homo_add, rand_residue(), rand_residue(), 1'b0);
        end

        // Scalar multiplication, corner scalars first
        send_task(cmd_scalar_mul, rand_residue(), 64'd0, 1'b0);
        send_task(cmd_scalar_mul, rand_residue(), 64'd1, 1'b0);
        send_task(cmd_scalar_mul, rand_residue(), '1, 1'b0);
        for (int i = 0; i < 6; i++) begin
            send_task(cmd_scalar_mul, rand_residue(), {$urandom(), $urandom()}, 1'b0);
        end

        // Same operands with and without idle cycles between limbs
        for (int i = 0; i < 4; i++) begin
            cmd = ($urandom_range(0, 1) == 0) ? cmd_homo_add : cmd_scalar_mul;
            a   = rand_residue();
            b   = rand_residue();
            send_task(cmd, a, b, 1'b0);
            send_task(cmd, a, b, 1'b1);
        end

        // Mixed commands, each issued as soon as task_ready allows
        for (int i = 0; i < 10; i++) begin
            cmd = ($urandom_range(0, 1) == 0) ? cmd_homo_add : cmd_scalar_mul;
            send_task(cmd, rand_residue(), rand_residue(), 1'b0);
        end

        wait_for_drain();
        $display("%0d results checked", results_seen);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+test
hdl/paillier_pkg.sv
hdl/mod_mult.sv
hdl/operand_collector.sv
hdl/homo_op_engine.sv
hdl/result_serializer.sv
hdl/paillier_top.sv
test/tb_paillier_top.sv

/* Makefile */
TOOL       = verilator
TOP        = tb_paillier_top
RTL_TOP    = paillier_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert -Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only -Wall --timing
PASS_MSG   = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
